// ==== ex_pkg.sv ====
package ex_pkg;

    localparam int data_width = 32;

    // bit 5 marks mul/div, bit 0 on alu ops selects the subtracting adder
    typedef enum logic [5:0] {
        op_add   = 6'h00,
        op_sub   = 6'h01,
        op_and   = 6'h02,
        op_slt   = 6'h03,
        op_or    = 6'h04,
        op_sltu  = 6'h05,
        op_xor   = 6'h06,
        op_nor   = 6'h08,
        op_sll   = 6'h0a,
        op_srl   = 6'h0c,
        op_sra   = 6'h0e,
        op_mul   = 6'h20,
        op_mulh  = 6'h21,
        op_mulhu = 6'h22,
        op_div   = 6'h24,
        op_divu  = 6'h25,
        op_mod   = 6'h26,
        op_modu  = 6'h27
    } ex_op_t;

    typedef enum logic [1:0] {
        lsu_none = 2'd0,
        lsu_byte = 2'd1,
        lsu_half = 2'd2,
        lsu_word = 2'd3
    } lsu_op_t;

    typedef struct packed {
        ex_op_t                op;
        logic [data_width-1:0] oprand1;
        logic [data_width-1:0] oprand2;
        logic [data_width-1:0] pc;
        logic                  rw_en;
        logic [4:0]            rw_addr;
        lsu_op_t               lsu_op;
    } ex_issue_t;

    typedef struct packed {
        ex_op_t                op;         // still needed for mdu select
        logic [data_width-1:0] alu_result;
        logic [data_width-1:0] quotient;
        logic [data_width-1:0] remainder;
        logic                  ale;
        logic [data_width-1:0] pc;
        logic                  rw_en;
        logic [4:0]            rw_addr;
        lsu_op_t               lsu_op;
    } ex_mid_t;

    typedef struct packed {
        logic [data_width-1:0] result;
        logic                  ale;
        logic [data_width-1:0] pc;
        logic                  rw_en;
        logic [4:0]            rw_addr;
        lsu_op_t               lsu_op;
    } ex_done_t;

endpackage

// ==== ex_stage_reg.sv ====
`timescale 1ns/1ns

module ex_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            out_payload <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
                out_payload <= in_payload;  // bubbles keep the last item
        end
    end

    // downstream stages trust valid without qualification
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
    );

endmodule

// ==== ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::ex_op_t                op,
    input  logic [ex_pkg::data_width-1:0] oprand1,
    input  logic [ex_pkg::data_width-1:0] oprand2,
    input  ex_pkg::lsu_op_t               lsu_op,
    output logic [ex_pkg::data_width-1:0] result,
    output logic                          ale
);

    logic [ex_pkg::data_width-1:0] adder_b;
    logic [ex_pkg::data_width-1:0] add_res;
    logic                          cout;
    logic                          slt;
    logic                          sltu;

    // one adder for add, sub and both compares
    assign adder_b = op[0] ? ~oprand2 : oprand2;
    assign {cout, add_res} = {1'b0, oprand1} + {1'b0, adder_b}
                           + {{ex_pkg::data_width{1'b0}}, op[0]};

    // op1 negative and op2 positive, or same sign with a negative difference
    assign slt = (oprand1[ex_pkg::data_width-1] & ~oprand2[ex_pkg::data_width-1])
               | (~(oprand1[ex_pkg::data_width-1] ^ oprand2[ex_pkg::data_width-1])
                  & add_res[ex_pkg::data_width-1]);
    assign sltu = ~cout;  // borrow out

    always_comb
    begin
        case (op)
            ex_pkg::op_add, ex_pkg::op_sub:
                result = add_res;
            ex_pkg::op_and:
                result = oprand1 & oprand2;
            ex_pkg::op_or:
                result = oprand1 | oprand2;
            ex_pkg::op_xor:
                result = oprand1 ^ oprand2;
            ex_pkg::op_nor:
                result = ~(oprand1 | oprand2);
            ex_pkg::op_sll:
                result = oprand1 << oprand2[4:0];
            ex_pkg::op_srl:
                result = oprand1 >> oprand2[4:0];
            ex_pkg::op_sra:
                result = $signed(oprand1) >>> oprand2[4:0];  // sign fill
            ex_pkg::op_slt:
                result = {{(ex_pkg::data_width-1){1'b0}}, slt};
            ex_pkg::op_sltu:
                result = {{(ex_pkg::data_width-1){1'b0}}, sltu};
            default:
                result = '0;
        endcase
    end

    // add_res doubles as the load/store address
    always_comb
    begin
        case (lsu_op)
            ex_pkg::lsu_half: ale = add_res[0];
            ex_pkg::lsu_word: ale = |add_res[1:0];
            default:          ale = 1'b0;  // byte and none never trap
        endcase

        // decode only sends add with a memory access
        if (lsu_op != ex_pkg::lsu_none)
            a_lsu_is_add: assert (op == ex_pkg::op_add);
    end

endmodule

// ==== ex_mul.sv ====
`timescale 1ns/1ns

module ex_mul (
    input  logic           clk,
    input  logic           rst_n,
    input  ex_pkg::ex_op_t op,
    input  logic [31:0]    oprand1,
    input  logic [31:0]    oprand2,
    output logic [63:0]    product
);

    logic        sig;
    logic [31:0] mag1;
    logic [31:0] mag2;
    logic [31:0] pp_ll;
    logic [31:0] pp_lh;
    logic [31:0] pp_hl;
    logic [31:0] pp_hh;
    logic        neg;
    logic [63:0] sum;

    assign sig = (op != ex_pkg::op_mulhu);  // mulhu is the only unsigned one

    // magnitudes, 0x80000000 stays correct as unsigned
    assign mag1 = (sig && oprand1[31]) ? -oprand1 : oprand1;
    assign mag2 = (sig && oprand2[31]) ? -oprand2 : oprand2;

    // stage one, 16x16 partial products
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pp_ll <= '0;
            pp_lh <= '0;
            pp_hl <= '0;
            pp_hh <= '0;
            neg   <= 1'b0;
        end
        else
        begin
            pp_ll <= mag1[15:0]  * mag2[15:0];
            pp_lh <= mag1[15:0]  * mag2[31:16];
            pp_hl <= mag1[31:16] * mag2[15:0];
            pp_hh <= mag1[31:16] * mag2[31:16];
            neg   <= sig && (oprand1[31] ^ oprand2[31]);
        end
    end

    // stage two, hh and ll do not overlap so they concatenate
    assign sum = {pp_hh, pp_ll}
               + ({32'b0, pp_lh} << 16)
               + ({32'b0, pp_hl} << 16);

    assign product = neg ? -sum : sum;

endmodule

// ==== ex_div.sv ====
`timescale 1ns/1ns

module ex_div #(
    parameter int WIDTH = 32
) (
    input  ex_pkg::ex_op_t   op,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    logic             sig;
    logic             neg_q;
    logic             neg_r;
    logic [WIDTH-1:0] mag_a;
    logic [WIDTH-1:0] mag_b;
    logic [WIDTH-1:0] quo_u;
    logic [WIDTH-1:0] rem_u;

    assign sig   = (op != ex_pkg::op_divu) && (op != ex_pkg::op_modu);
    assign mag_a = (sig && dividend[WIDTH-1]) ? -dividend : dividend;
    assign mag_b = (sig && divisor[WIDTH-1]) ? -divisor : divisor;
    assign neg_q = sig && (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
    assign neg_r = sig && dividend[WIDTH-1];  // remainder follows dividend

    // restoring division, one quotient bit per row, msb first
    always_comb
    begin : restore
        logic [WIDTH:0]   trial;
        logic [WIDTH-1:0] part;

        part  = '0;
        quo_u = '0;
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            trial = {part, mag_a[i]};
            if (trial >= {1'b0, mag_b})
            begin
                trial    = trial - {1'b0, mag_b};
                quo_u[i] = 1'b1;
            end
            part = trial[WIDTH-1:0];
        end
        rem_u = part;
    end

    // min / -1 needs no special case, the negate wraps back to min
    always_comb
    begin
        if (divisor == '0)
        begin
            quotient  = '1;
            remainder = dividend;
        end
        else
        begin
            quotient  = neg_q ? -quo_u : quo_u;
            remainder = neg_r ? -rem_u : rem_u;
        end
    end

endmodule

// ==== ex_mdu.sv ====
`timescale 1ns/1ns

module ex_mdu (
    input  ex_pkg::ex_op_t                op,
    input  logic [63:0]                   product,
    input  logic [ex_pkg::data_width-1:0] quotient,
    input  logic [ex_pkg::data_width-1:0] remainder,
    output logic [ex_pkg::data_width-1:0] result
);

    always_comb
    begin
        case (op)
            ex_pkg::op_mul:
                result = product[31:0];
            ex_pkg::op_mulh, ex_pkg::op_mulhu:
                result = product[63:32];  // signedness already applied in ex_mul
            ex_pkg::op_div, ex_pkg::op_divu:
                result = quotient;
            ex_pkg::op_mod, ex_pkg::op_modu:
                result = remainder;
            default:
                result = '0;  // alu ops land here
        endcase

        // catches a corrupted op in the mid register
        a_op_known: assert (op inside {
            ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_and, ex_pkg::op_or,
            ex_pkg::op_xor, ex_pkg::op_nor, ex_pkg::op_sll, ex_pkg::op_srl,
            ex_pkg::op_sra, ex_pkg::op_slt, ex_pkg::op_sltu,
            ex_pkg::op_mul, ex_pkg::op_mulh, ex_pkg::op_mulhu,
            ex_pkg::op_div, ex_pkg::op_divu, ex_pkg::op_mod, ex_pkg::op_modu
        });
    end

endmodule

// ==== ex_unit.sv ====
`timescale 1ns/1ns

module ex_unit #(
    parameter int WIDTH = ex_pkg::data_width
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  ex_pkg::ex_op_t  in_op,
    input  logic [WIDTH-1:0] in_oprand1,
    input  logic [WIDTH-1:0] in_oprand2,
    input  logic [WIDTH-1:0] in_pc,
    input  logic            in_rw_en,
    input  logic [4:0]      in_rw_addr,
    input  ex_pkg::lsu_op_t in_lsu_op,
    output logic            out_valid,
    output logic [WIDTH-1:0] out_result,
    output logic            out_ale,
    output logic [WIDTH-1:0] out_pc,
    output logic            out_rw_en,
    output logic [4:0]      out_rw_addr,
    output ex_pkg::lsu_op_t out_lsu_op
);

    ex_pkg::ex_issue_t issue_d;
    ex_pkg::ex_issue_t issue_q;
    ex_pkg::ex_mid_t   mid_d;
    ex_pkg::ex_mid_t   mid_q;
    ex_pkg::ex_done_t  done_d;
    ex_pkg::ex_done_t  done_q;
    logic              issue_valid;
    logic              mid_valid;
    logic [WIDTH-1:0]  alu_result;
    logic              alu_ale;
    logic [WIDTH-1:0]  quotient;
    logic [WIDTH-1:0]  remainder;
    logic [63:0]       product;
    logic [WIDTH-1:0]  mdu_result;

    assign issue_d = '{op: in_op, oprand1: in_oprand1, oprand2: in_oprand2, pc: in_pc,
                       rw_en: in_rw_en, rw_addr: in_rw_addr, lsu_op: in_lsu_op};

    ex_stage_reg #(.payload_t(ex_pkg::ex_issue_t)) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_payload  (issue_d),
        .out_valid   (issue_valid),
        .out_payload (issue_q)
    );

    // compute stage
    ex_alu u_alu (
        .op      (issue_q.op),
        .oprand1 (issue_q.oprand1),
        .oprand2 (issue_q.oprand2),
        .lsu_op  (issue_q.lsu_op),
        .result  (alu_result),
        .ale     (alu_ale)
    );

    ex_div #(.WIDTH(WIDTH)) u_div (
        .op        (issue_q.op),
        .dividend  (issue_q.oprand1),
        .divisor   (issue_q.oprand2),
        .quotient  (quotient),
        .remainder (remainder)
    );

    ex_mul u_mul (  // registers in step with u_mid
        .clk     (clk),
        .rst_n   (rst_n),
        .op      (issue_q.op),
        .oprand1 (issue_q.oprand1),
        .oprand2 (issue_q.oprand2),
        .product (product)
    );

    assign mid_d = '{op: issue_q.op, alu_result: alu_result, quotient: quotient,
                     remainder: remainder, ale: alu_ale, pc: issue_q.pc,
                     rw_en: issue_q.rw_en, rw_addr: issue_q.rw_addr,
                     lsu_op: issue_q.lsu_op};

    ex_stage_reg #(.payload_t(ex_pkg::ex_mid_t)) u_mid (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (issue_valid),
        .in_payload  (mid_d),
        .out_valid   (mid_valid),
        .out_payload (mid_q)
    );

    // result stage
    ex_mdu u_mdu (
        .op        (mid_q.op),
        .product   (product),
        .quotient  (mid_q.quotient),
        .remainder (mid_q.remainder),
        .result    (mdu_result)
    );

    assign done_d = '{result: mid_q.op[5] ? mdu_result : mid_q.alu_result,
                      ale: mid_q.ale, pc: mid_q.pc, rw_en: mid_q.rw_en,
                      rw_addr: mid_q.rw_addr, lsu_op: mid_q.lsu_op};

    ex_stage_reg #(.payload_t(ex_pkg::ex_done_t)) u_done (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (mid_valid),
        .in_payload  (done_d),
        .out_valid   (out_valid),
        .out_payload (done_q)
    );

    assign out_result  = done_q.result;
    assign out_ale     = done_q.ale;
    assign out_pc      = done_q.pc;
    assign out_rw_en   = done_q.rw_en;  // not masked by ale here
    assign out_rw_addr = done_q.rw_addr;
    assign out_lsu_op  = done_q.lsu_op;

    // fixed latency, and the pc comes out with its own item
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 (out_valid && out_pc == $past(in_pc, 3))
    );

endmodule

// ==== tb_ex_unit.sv ====
`timescale 1ns/1ns

module tb_ex_unit;

    localparam int n_random = 40;
    localparam int period   = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    ex_pkg::ex_op_t        in_op;
    logic [31:0]           in_oprand1;
    logic [31:0]           in_oprand2;
    logic [31:0]           in_pc;
    logic                  in_rw_en;
    logic [4:0]            in_rw_addr;
    ex_pkg::lsu_op_t       in_lsu_op;
    logic                  out_valid;
    logic [31:0]           out_result;
    logic                  out_ale;
    logic [31:0]           out_pc;
    logic                  out_rw_en;
    logic [4:0]            out_rw_addr;
    ex_pkg::lsu_op_t       out_lsu_op;

    // stimulus table with one row per index across the queues
    string                 t_name[$];
    ex_pkg::ex_op_t        t_op[$];
    logic [31:0]           t_a[$];
    logic [31:0]           t_b[$];
    ex_pkg::lsu_op_t       t_lsu[$];
    logic [31:0]           t_res[$];
    logic                  t_ale[$];

    int                    pending[$];      // table rows in flight with the oldest first
    int                    issue_cycle[$];
    int                    cycle       = 0;
    int                    n_directed  = 0;
    int                    errors      = 0;
    logic                  table_ready = 1'b0;

    ex_pkg::ex_op_t op_list [18] = '{
        ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_and, ex_pkg::op_or,
        ex_pkg::op_xor, ex_pkg::op_nor, ex_pkg::op_sll, ex_pkg::op_srl,
        ex_pkg::op_sra, ex_pkg::op_slt, ex_pkg::op_sltu, ex_pkg::op_mul,
        ex_pkg::op_mulh, ex_pkg::op_mulhu, ex_pkg::op_div, ex_pkg::op_divu,
        ex_pkg::op_mod, ex_pkg::op_modu
    };

    ex_unit #(.WIDTH(ex_pkg::data_width)) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_oprand1  (in_oprand1),
        .in_oprand2  (in_oprand2),
        .in_pc       (in_pc),
        .in_rw_en    (in_rw_en),
        .in_rw_addr  (in_rw_addr),
        .in_lsu_op   (in_lsu_op),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_ale     (out_ale),
        .out_pc      (out_pc),
        .out_rw_en   (out_rw_en),
        .out_rw_addr (out_rw_addr),
        .out_lsu_op  (out_lsu_op)
    );

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // expected result straight from the instruction semantics
    function automatic logic [31:0] model_result(ex_pkg::ex_op_t op, logic [31:0] a,
                                                 logic [31:0] b);
        logic [63:0] sprod;
        logic [63:0] uprod;
        logic        min_by_neg1;

        sprod       = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits are exact
        uprod       = {32'b0, a} * {32'b0, b};
        min_by_neg1 = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            ex_pkg::op_add:   return a + b;
            ex_pkg::op_sub:   return a - b;
            ex_pkg::op_and:   return a & b;
            ex_pkg::op_or:    return a | b;
            ex_pkg::op_xor:   return a ^ b;
            ex_pkg::op_nor:   return ~(a | b);
            ex_pkg::op_sll:   return a << b[4:0];
            ex_pkg::op_srl:   return a >> b[4:0];
            ex_pkg::op_sra:   return $signed(a) >>> b[4:0];
            ex_pkg::op_slt:   return {31'b0, $signed(a) < $signed(b)};
            ex_pkg::op_sltu:  return {31'b0, a < b};
            ex_pkg::op_mul:   return sprod[31:0];
            ex_pkg::op_mulh:  return sprod[63:32];
            ex_pkg::op_mulhu: return uprod[63:32];
            ex_pkg::op_div:
            begin
                if (b == 0)
                    return 32'hffff_ffff;
                else if (min_by_neg1)
                    return a;
                else
                    return $signed(a) / $signed(b);  // truncates toward zero
            end
            ex_pkg::op_mod:
            begin
                if (b == 0)
                    return a;
                else if (min_by_neg1)
                    return 32'h0;
                else
                    return $signed(a) % $signed(b);  // takes the dividend's sign
            end
            ex_pkg::op_divu:  return (b == 0) ? 32'hffff_ffff : a / b;
            ex_pkg::op_modu:  return (b == 0) ? a : a % b;
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic model_ale(ex_pkg::lsu_op_t lsu, logic [31:0] a, logic [31:0] b);
        logic [31:0] addr;

        addr = a + b;
        case (lsu)
            ex_pkg::lsu_half: return addr[0];
            ex_pkg::lsu_word: return addr[1:0] != 2'b00;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] pc_of(int idx);
        return 32'h1c00_0000 + 32'(idx) * 4;
    endfunction

    task automatic add_entry(input string name, input ex_pkg::ex_op_t op,
                             input logic [31:0] a, input logic [31:0] b,
                             input ex_pkg::lsu_op_t lsu = ex_pkg::lsu_none);
        t_name.push_back(name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_lsu.push_back(lsu);
        t_res.push_back(model_result(op, a, b));
        t_ale.push_back(model_ale(lsu, a, b));
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, field, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic build_table();
        add_entry("add_basic", ex_pkg::op_add, 32'd1234, 32'd4321);
        add_entry("add_wrap", ex_pkg::op_add, 32'h7fff_ffff, 32'h1);
        add_entry("sub_neg", ex_pkg::op_sub, 32'h0, 32'h1);
        add_entry("sub_min", ex_pkg::op_sub, 32'h8000_0000, 32'h1);
        add_entry("and", ex_pkg::op_and, 32'hf0f0_ff00, 32'h0ff0_f0f0);
        add_entry("or", ex_pkg::op_or, 32'hf0f0_0000, 32'h0000_0f0f);
        add_entry("xor", ex_pkg::op_xor, 32'haaaa_5555, 32'hffff_0000);
        add_entry("nor", ex_pkg::op_nor, 32'h1234_0000, 32'h0000_5678);
        add_entry("slt_neg_pos", ex_pkg::op_slt, 32'hffff_ffff, 32'h1);
        add_entry("slt_pos_neg", ex_pkg::op_slt, 32'h1, 32'hffff_ffff);
        add_entry("slt_min_max", ex_pkg::op_slt, 32'h8000_0000, 32'h7fff_ffff);
        add_entry("slt_equal", ex_pkg::op_slt, 32'h8000_0000, 32'h8000_0000);
        add_entry("sltu_small", ex_pkg::op_sltu, 32'h1, 32'hffff_ffff);
        add_entry("sltu_big", ex_pkg::op_sltu, 32'hffff_ffff, 32'h1);
        add_entry("sll_4", ex_pkg::op_sll, 32'h8765_4321, 32'h4);
        add_entry("sll_low5", ex_pkg::op_sll, 32'h8765_4321, 32'h24);   // shifts by 4
        add_entry("srl_31", ex_pkg::op_srl, 32'h8000_0000, 32'd31);
        add_entry("srl_32", ex_pkg::op_srl, 32'h8000_0000, 32'h20);     // shifts by 0
        add_entry("sra_fill", ex_pkg::op_sra, 32'h8000_0000, 32'h4);
        add_entry("sra_63", ex_pkg::op_sra, 32'h8000_0001, 32'h3f);
        add_entry("mul_small", ex_pkg::op_mul, 32'd3, 32'hffff_fffb);
        add_entry("mul_ones", ex_pkg::op_mul, 32'hffff_ffff, 32'hffff_ffff);
        add_entry("mulh_ones", ex_pkg::op_mulh, 32'hffff_ffff, 32'hffff_ffff);
        add_entry("mulh_min", ex_pkg::op_mulh, 32'h8000_0000, 32'h8000_0000);
        add_entry("mulh_mixed", ex_pkg::op_mulh, 32'h7fff_ffff, 32'h8000_0000);
        add_entry("mulhu_ones", ex_pkg::op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
        add_entry("div_neg", ex_pkg::op_div, 32'hffff_fff9, 32'd2);
        add_entry("mod_neg", ex_pkg::op_mod, 32'hffff_fff9, 32'd2);
        add_entry("mod_negdiv", ex_pkg::op_mod, 32'd7, 32'hffff_fffe);
        add_entry("divu_big", ex_pkg::op_divu, 32'hffff_ffff, 32'd2);
        add_entry("modu_big", ex_pkg::op_modu, 32'hffff_ffff, 32'd10);
        add_entry("div_zero", ex_pkg::op_div, 32'h8765_4321, 32'h0);
        add_entry("mod_zero", ex_pkg::op_mod, 32'h8765_4321, 32'h0);
        add_entry("divu_zero", ex_pkg::op_divu, 32'h1234_5678, 32'h0);
        add_entry("div_min_m1", ex_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
        add_entry("mod_min_m1", ex_pkg::op_mod, 32'h8000_0000, 32'hffff_ffff);
        add_entry("ale_half_odd", ex_pkg::op_add, 32'h1000, 32'h1, ex_pkg::lsu_half);
        add_entry("ale_half_even", ex_pkg::op_add, 32'h1000, 32'h2, ex_pkg::lsu_half);
        add_entry("ale_word_2", ex_pkg::op_add, 32'h1000, 32'h2, ex_pkg::lsu_word);
        add_entry("ale_word_ok", ex_pkg::op_add, 32'h1008, 32'hffff_fffc, ex_pkg::lsu_word);
        add_entry("ale_byte", ex_pkg::op_add, 32'h1003, 32'h0, ex_pkg::lsu_byte);
        n_directed = t_name.size();
        for (int i = 0; i < n_random; i++)
        begin
            // every fourth divisor kept small so divides give non-trivial results
            add_entry($sformatf("random_%0d", i), op_list[$urandom_range(0, 17)], $urandom,
                      (i % 4 == 3) ? 32'($urandom_range(0, 15)) : $urandom);
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    initial
    begin : monitor
        int idx;
        int issued;

        forever
        begin
            @(negedge clk);
            if (rst_n && out_valid)
            begin
                if (pending.size() == 0)
                begin
                    $display("out_valid was high with no item in flight");
                    $display("Checks failed");
                    $fatal(1, "unexpected output");
                end
                else
                begin
                    idx    = pending.pop_front();
                    issued = issue_cycle.pop_front();
                    check_value(t_name[idx], "result", t_res[idx], out_result);
                    check_value(t_name[idx], "ale", {31'b0, t_ale[idx]}, {31'b0, out_ale});
                    check_value(t_name[idx], "pc", pc_of(idx), out_pc);
                    check_value(t_name[idx], "rw_en", 32'(idx % 2), {31'b0, out_rw_en});
                    check_value(t_name[idx], "rw_addr", 32'(idx % 32), {27'b0, out_rw_addr});
                    check_value(t_name[idx], "lsu_op", {30'b0, t_lsu[idx]}, {30'b0, out_lsu_op});
                    // three register stages counted from the drive cycle
                    check_value(t_name[idx], "latency", 32'd3, 32'(cycle - issued));
                end
            end
        end
    end

    initial
    begin : stimulus
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = ex_pkg::op_add;
        in_oprand1 = '0;
        in_oprand2 = '0;
        in_pc      = '0;
        in_rw_en   = 1'b0;
        in_rw_addr = '0;
        in_lsu_op  = ex_pkg::lsu_none;
        void'($urandom(32'h80d3));
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("reset", "out_valid", 32'd0, {31'b0, out_valid});

        for (int i = 0; i < t_name.size(); i++)
        begin
            @(posedge clk);
            #2;
            in_valid   = 1'b1;
            in_op      = t_op[i];
            in_oprand1 = t_a[i];
            in_oprand2 = t_b[i];
            in_lsu_op  = t_lsu[i];
            in_pc      = pc_of(i);
            in_rw_en   = 1'(i % 2);
            in_rw_addr = 5'(i % 32);
            pending.push_back(i);
            issue_cycle.push_back(cycle);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;

        while (pending.size() != 0)
            @(negedge clk);

        if (errors == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Checks failed");
            $fatal(1, "errors seen");
        end
    end

    initial
    begin : watchdog
        int limit_ns;

        wait (table_ready);
        limit_ns = (n_directed + n_random + 10) * period;
        #(limit_ns);
        $display("timeout, results still outstanding after %0d ns", limit_ns);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
ex_pkg.sv
ex_stage_reg.sv
ex_alu.sv
ex_mul.sv
ex_div.sv
ex_mdu.sv
ex_unit.sv
tb_ex_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ex_unit testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f run.log
(verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_unit \
    -f compile.f -o sim_ex_unit && ./obj_dir/sim_ex_unit) > run.log 2>&1 \
    || echo "Checks failed" >> run.log
cat run.log
grep -q "Checks failed" run.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
